/* logic/mem_share_pkg.sv */
`default_nettype none

package mem_share_pkg;

    // ========================================
    // memory geometry
    // ========================================

    // word address into the shared sram
    localparam int ADDR_W = 8;
    // width of one data word
    localparam int DATA_W = 16;

    // address of one memory word
    typedef logic [ADDR_W-1:0] mem_addr_t;
    // one data word, read or written
    typedef logic [DATA_W-1:0] mem_data_t;

    // ========================================
    // command and client types
    // ========================================

    // one memory command as it travels from client to port
    // wr set means write, clear means read
    typedef struct packed {
        logic      wr;
        mem_addr_t addr;
        mem_data_t data;
    } mem_cmd_t;

    // client request FSM
    // IDLE while the command FIFO is empty, REQ while it holds work
    typedef enum logic {
        IDLE = 1'b0,
        REQ  = 1'b1
    } client_state_t;

endpackage : mem_share_pkg

`default_nettype wire

/* logic/leading_one_trailing_one.sv */
`timescale 1ns/100ps
`default_nettype none

module leading_one_trailing_one #(
    parameter int WIDTH = 4
) (
    input  wire logic [WIDTH-1:0]                     i_data,
    output logic      [((WIDTH > 1) ? $clog2(WIDTH) : 1)-1:0] ow_leadingone,
    output logic      [WIDTH-1:0]                     ow_leadingone_vector,
    output logic      [((WIDTH > 1) ? $clog2(WIDTH) : 1)-1:0] ow_trailingone,
    output logic      [WIDTH-1:0]                     ow_trailingone_vector,
    output logic                                      ow_all_zeroes,
    output logic                                      ow_valid
);

    // width of a bit position
    localparam int POS_W = (WIDTH > 1) ? $clog2(WIDTH) : 1;

    // ========================================
    // bit position search
    // ========================================

    // leading one is the highest set bit, trailing one the lowest
    // both default to position zero when no bit is set
    always_comb
    begin
        ow_leadingone  = '0;
        ow_trailingone = '0;
        // upward scan, the last hit is the highest bit
        for (int i = 0; i < WIDTH; i++)
        begin
            if (i_data[i])
                ow_leadingone = POS_W'(i);
        end
        // downward scan, the last hit is the lowest bit
        for (int i = WIDTH - 1; i >= 0; i--)
        begin
            if (i_data[i])
                ow_trailingone = POS_W'(i);
        end
    end

    // ========================================
    // one-hot vectors and flags
    // ========================================

    // any bit set at all
    assign ow_valid      = |i_data;
    assign ow_all_zeroes = ~ow_valid;

    // highest set bit as a one-hot vector, zero when nothing is set
    assign ow_leadingone_vector = ow_valid ? (WIDTH'(1) << ow_leadingone) : '0;

    // two's complement trick isolates the lowest set bit
    assign ow_trailingone_vector = i_data & (~i_data + WIDTH'(1));

endmodule : leading_one_trailing_one

`default_nettype wire

/* logic/round_robin_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module round_robin_arbiter #(
    parameter int CLIENTS = 4
) (
    input  wire logic               i_clk,
    input  wire logic               i_rst_n,
    input  wire logic               i_block_arb,
    input  wire logic [CLIENTS-1:0] i_req,
    output logic      [CLIENTS-1:0] o_gnt
);

    // bits strictly below the previous winner
    logic [CLIENTS-1:0] r_mask;
    // every bit except the previous winner
    logic [CLIENTS-1:0] r_win_mask_only;

    // requests after the block input
    logic [CLIENTS-1:0] w_req_post;
    // requests below the previous winner
    logic [CLIENTS-1:0] w_req_masked;
    // wrap-around candidates
    logic [CLIENTS-1:0] w_req_win_mask;

    logic [CLIENTS-1:0] w_req_vec;
    logic [CLIENTS-1:0] w_reqm_vec;
    logic               w_vld_req;
    logic               w_vld_reqm;
    // one-hot winner or zero when nobody wins
    logic [CLIENTS-1:0] w_win_vec;

    // ========================================
    // request masking
    // ========================================

    // block freezes arbitration by hiding all requests
    assign w_req_post   = i_block_arb ? '0 : i_req;
    assign w_req_masked = w_req_post & r_mask;

    // previous winner only drops out of the wrap-around choice
    // when somebody else is also asking
    assign w_req_win_mask = ($countones(w_req_post) > 1) ?
                            (w_req_post & r_win_mask_only) : w_req_post;

    // ========================================
    // winner search
    // ========================================

    // highest bit of the wrap-around candidates
    leading_one_trailing_one #(
        .WIDTH (CLIENTS)
    ) u_req_leading_one_trailing_one (
        .i_data                (w_req_win_mask),
        .ow_leadingone         (),
        .ow_leadingone_vector  (w_req_vec),
        .ow_trailingone        (),
        .ow_trailingone_vector (),
        .ow_all_zeroes         (),
        .ow_valid              (w_vld_req)
    );

    // highest bit among requests below the previous winner
    leading_one_trailing_one #(
        .WIDTH (CLIENTS)
    ) u_reqm_leading_one_trailing_one (
        .i_data                (w_req_masked),
        .ow_leadingone         (),
        .ow_leadingone_vector  (w_reqm_vec),
        .ow_trailingone        (),
        .ow_trailingone_vector (),
        .ow_all_zeroes         (),
        .ow_valid              (w_vld_reqm)
    );

    // masked search has priority, otherwise start over from the top
    always_comb
    begin
        if (w_vld_reqm)
            w_win_vec = w_reqm_vec;
        else if (w_vld_req)
            w_win_vec = w_req_vec;
        else
            w_win_vec = '0;
    end

    // ========================================
    // grant and mask registers
    // ========================================

    // masks only move on a real win, so they always name the last grant
    // reset state has no previous winner and so starts at the top bit
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            r_mask          <= '0;
            r_win_mask_only <= '1;
        end
        else if (|w_win_vec)
        begin
            r_mask          <= w_win_vec - CLIENTS'(1);
            r_win_mask_only <= ~w_win_vec;
        end
    end

    // one cycle grant pulse
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
            o_gnt <= '0;
        else
            o_gnt <= w_win_vec;
    end

    // ========================================
    // assertions
    // ========================================

    a_gnt_onehot0 : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $onehot0(o_gnt));

    // grant only to a client that asked in the cycle before
    a_gnt_had_req : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_gnt & ~$past(i_req)) == '0);

endmodule : round_robin_arbiter

`default_nettype wire

/* logic/mem_client.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_client #(
    parameter int FIFO_DEPTH = 2
) (
    input  wire logic                  i_clk,
    input  wire logic                  i_rst_n,
    input  wire logic                  i_cmd_valid,
    input  wire mem_share_pkg::mem_cmd_t i_cmd,
    output logic                       o_cmd_ready,
    input  wire logic                  i_gnt,
    output logic                       o_req,
    output mem_share_pkg::mem_cmd_t    o_cmd_head
);

    // pointer and occupancy widths
    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    // command storage holding the payload only
    mem_share_pkg::mem_cmd_t r_fifo [FIFO_DEPTH];

    logic [PTR_W-1:0] r_wr_ptr;
    logic [PTR_W-1:0] r_rd_ptr;
    logic [CNT_W-1:0] r_count;

    mem_share_pkg::client_state_t r_state;

    logic w_push;
    logic w_pop;
    logic w_full;

    // ========================================
    // handshake
    // ========================================

    // full FIFO is the only source of back-pressure
    assign w_full      = (r_count == CNT_W'(FIFO_DEPTH));
    assign o_cmd_ready = ~w_full;
    assign w_push      = i_cmd_valid & o_cmd_ready;

    // a grant always consumes the head entry
    assign w_pop = i_gnt;

    // head is always on the port and the sram side picks it by grant
    assign o_cmd_head = r_fifo[r_rd_ptr];

    // request drops during the grant cycle
    // arbiter still sees the old level for one more cycle otherwise
    assign o_req = (r_state == mem_share_pkg::REQ) & ~i_gnt;

    // ========================================
    // circular FIFO
    // ========================================

    // depth is a power of two so pointers wrap by themselves
    always_ff @(posedge i_clk)
    begin
        if (w_push)
            r_fifo[r_wr_ptr] <= i_cmd;
    end

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            r_wr_ptr <= '0;
            r_rd_ptr <= '0;
            r_count  <= '0;
        end
        else
        begin
            if (w_push)
                r_wr_ptr <= r_wr_ptr + PTR_W'(1);
            if (w_pop)
                r_rd_ptr <= r_rd_ptr + PTR_W'(1);
            // occupancy moves only when push and pop differ
            case ({w_push, w_pop})
                2'b10:   r_count <= r_count + CNT_W'(1);
                2'b01:   r_count <= r_count - CNT_W'(1);
                default: r_count <= r_count;
            endcase
        end
    end

    // ========================================
    // request FSM
    // ========================================

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
            r_state <= mem_share_pkg::IDLE;
        else
        begin
            case (r_state)
                mem_share_pkg::IDLE:
                begin
                    // first command arrives
                    if (w_push)
                        r_state <= mem_share_pkg::REQ;
                end
                mem_share_pkg::REQ:
                begin
                    // last entry leaves with nothing new behind it
                    if (w_pop && !w_push && r_count == CNT_W'(1))
                        r_state <= mem_share_pkg::IDLE;
                end
                default: r_state <= mem_share_pkg::IDLE;
            endcase
        end
    end

    // ========================================
    // assertions
    // ========================================

    // arbiter never grants a client that has nothing queued
    a_no_gnt_idle : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_gnt |-> (r_state == mem_share_pkg::REQ));

endmodule : mem_client

`default_nettype wire

/* logic/sram_port.sv */
`timescale 1ns/100ps
`default_nettype none

module sram_port #(
    parameter int NUM_CLIENTS = 4
) (
    input  wire logic                    i_clk,
    input  wire logic                    i_rst_n,
    input  wire logic [NUM_CLIENTS-1:0]  i_gnt,
    input  wire mem_share_pkg::mem_cmd_t i_cmd [NUM_CLIENTS],
    output logic      [NUM_CLIENTS-1:0]  o_rd_valid,
    output mem_share_pkg::mem_data_t     o_rd_data
);

    // one word per address
    localparam int MEM_WORDS = 2 ** mem_share_pkg::ADDR_W;
    localparam int CMD_W     = $bits(mem_share_pkg::mem_cmd_t);

    mem_share_pkg::mem_data_t r_mem [MEM_WORDS];

    // command of the granted client
    mem_share_pkg::mem_cmd_t w_sel;
    // some client owns the port this cycle
    logic                    w_access;

    // ========================================
    // command select
    // ========================================

    // grant is one-hot, so an OR of gated heads is a mux
    always_comb
    begin
        w_sel = '0;
        for (int k = 0; k < NUM_CLIENTS; k++)
        begin
            w_sel = w_sel | (i_cmd[k] & {CMD_W{i_gnt[k]}});
        end
    end

    assign w_access = |i_gnt;

    // ========================================
    // memory array
    // ========================================

    // single port, write or registered read each cycle
    always_ff @(posedge i_clk)
    begin
        if (w_access)
        begin
            if (w_sel.wr)
                r_mem[w_sel.addr] <= w_sel.data;
            else
                o_rd_data <= r_mem[w_sel.addr];
        end
    end

    // ========================================
    // read return
    // ========================================

    // the grant travels with the data as the response tag
    // writes return nothing
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
            o_rd_valid <= '0;
        else
            o_rd_valid <= i_gnt & {NUM_CLIENTS{~w_sel.wr}};
    end

    // ========================================
    // assertions
    // ========================================

    // two owners at once would corrupt the selected command
    a_gnt_onehot0 : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $onehot0(i_gnt));

endmodule : sram_port

`default_nettype wire

/* logic/mem_share_top.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_share_top #(
    parameter int NUM_CLIENTS = 4,
    parameter int FIFO_DEPTH  = 2
) (
    input  wire logic                    i_clk,
    input  wire logic                    i_rst_n,
    input  wire logic                    i_block_arb,
    input  wire logic [NUM_CLIENTS-1:0]  i_cmd_valid,
    input  wire mem_share_pkg::mem_cmd_t i_cmd [NUM_CLIENTS],
    output logic      [NUM_CLIENTS-1:0]  o_cmd_ready,
    output logic      [NUM_CLIENTS-1:0]  o_gnt,
    output logic      [NUM_CLIENTS-1:0]  o_rd_valid,
    output mem_share_pkg::mem_data_t     o_rd_data
);

    // request levels from the clients
    logic [NUM_CLIENTS-1:0] w_req;
    // FIFO heads, one per client
    mem_share_pkg::mem_cmd_t w_cmd_head [NUM_CLIENTS];

    // ========================================
    // arbiter
    // ========================================

    round_robin_arbiter #(
        .CLIENTS (NUM_CLIENTS)
    ) u_round_robin_arbiter (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_block_arb (i_block_arb),
        .i_req       (w_req),
        .o_gnt       (o_gnt)
    );

    // ========================================
    // clients
    // ========================================

    for (genvar g = 0; g < NUM_CLIENTS; g++)
    begin : g_client
        mem_client #(
            .FIFO_DEPTH (FIFO_DEPTH)
        ) u_mem_client (
            .i_clk       (i_clk),
            .i_rst_n     (i_rst_n),
            .i_cmd_valid (i_cmd_valid[g]),
            .i_cmd       (i_cmd[g]),
            .o_cmd_ready (o_cmd_ready[g]),
            .i_gnt       (o_gnt[g]),
            .o_req       (w_req[g]),
            .o_cmd_head  (w_cmd_head[g])
        );
    end

    // ========================================
    // shared memory port
    // ========================================

    sram_port #(
        .NUM_CLIENTS (NUM_CLIENTS)
    ) u_sram_port (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_gnt      (o_gnt),
        .i_cmd      (w_cmd_head),
        .o_rd_valid (o_rd_valid),
        .o_rd_data  (o_rd_data)
    );

endmodule : mem_share_top

`default_nettype wire

/* tests/mem_share_model.svh */
`ifndef MEM_SHARE_MODEL_SVH
`define MEM_SHARE_MODEL_SVH

// ========================================
// random source
// ========================================

// fibonacci lfsr, taps at bits 32 22 2 1
logic [31:0] lfsr_state = 32'h0443965e;

// one lfsr step per returned bit, first bit ends up highest
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++)
    begin
        fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        val        = {val[30:0], fb};
    end
    return val;
endfunction

// single compare point for every value the testbench checks
task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
        $display("[FAIL] %0t: %s, got %0h, expected %0h", $time, what, got, exp);
        abort_run();
    end
endtask

// ========================================
// reference memory
// ========================================

// clients own disjoint address ranges, so one array serves as all four models
mem_share_pkg::mem_data_t model_mem     [2 ** mem_share_pkg::ADDR_W];
bit                       model_written [2 ** mem_share_pkg::ADDR_W];

// expected read data per client, oldest first
mem_share_pkg::mem_data_t exp_rd_q [NUM_CLIENTS][$];
// accepted commands still waiting for a grant
int                       pending_cnt [NUM_CLIENTS];

// model side of an accepted command
task automatic model_accept(input int k, input mem_share_pkg::mem_cmd_t c);
    if (c.wr)
    begin
        model_mem[c.addr]     = c.data;
        model_written[c.addr] = 1'b1;
    end
    else
        exp_rd_q[k].push_back(model_mem[c.addr]);
    pending_cnt[k]++;
endtask

`endif

/* tests/mem_share_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_share_tb;

    localparam int NUM_CLIENTS = 4;
    localparam int FIFO_DEPTH  = 2;
    // cycles any single wait may take
    localparam int TIMEOUT     = 200;
    localparam int NUM_RANDOM  = 400;

    logic                     clk;
    logic                     rst_n;
    logic                     block_arb;
    logic [NUM_CLIENTS-1:0]   cmd_valid;
    mem_share_pkg::mem_cmd_t  cmd [NUM_CLIENTS];
    logic [NUM_CLIENTS-1:0]   cmd_ready;
    logic [NUM_CLIENTS-1:0]   gnt;
    logic [NUM_CLIENTS-1:0]   rd_valid;
    mem_share_pkg::mem_data_t rd_data;

    // arbiter model state
    logic [NUM_CLIENTS-1:0]   exp_gnt;
    logic [NUM_CLIENTS-1:0]   model_req;
    bit                       have_prev;
    int                       prev_win;

    `include "mem_share_model.svh"

    mem_share_top #(
        .NUM_CLIENTS (NUM_CLIENTS),
        .FIFO_DEPTH  (FIFO_DEPTH)
    ) u_mem_share_top (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_block_arb (block_arb),
        .i_cmd_valid (cmd_valid),
        .i_cmd       (cmd),
        .o_cmd_ready (cmd_ready),
        .o_gnt       (gnt),
        .o_rd_valid  (rd_valid),
        .o_rd_data   (rd_data)
    );

    always #4 clk = ~clk;

    task automatic abort_run();
        $display("test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s after %0d cycles", what, TIMEOUT);
        abort_run();
    endtask

    // ========================================
    // arbitration rule
    // ========================================

    // highest requester below the last winner, else the highest one,
    // the last winner sitting out the wrap when others also ask
    function automatic logic [NUM_CLIENTS-1:0] predict_grant(
        input logic [NUM_CLIENTS-1:0] req,
        input logic                   blocked,
        input bit                     prev_ok,
        input int                     prev
    );
        logic [NUM_CLIENTS-1:0] cand;
        int                     win;
        win = -1;
        if (blocked)
            return '0;
        if (prev_ok)
        begin
            for (int i = 0; i < prev; i++)
            begin
                if (req[i])
                    win = i;
            end
        end
        if (win < 0)
        begin
            cand = req;
            if (prev_ok && $countones(req) > 1)
                cand[prev] = 1'b0;
            for (int i = 0; i < NUM_CLIENTS; i++)
            begin
                if (cand[i])
                    win = i;
            end
        end
        if (win < 0)
            return '0;
        return NUM_CLIENTS'(1) << win;
    endfunction

    // ========================================
    // scoreboard, sampled at the rising edge
    // ========================================

    // values seen here are the ones held through the cycle that ends now
    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            exp_gnt   = '0;
            have_prev = 1'b0;
            prev_win  = 0;
            for (int k = 0; k < NUM_CLIENTS; k++)
            begin
                pending_cnt[k] = 0;
                exp_rd_q[k].delete();
            end
        end
        else
        begin
            check_value("grant vector", 32'(gnt), 32'(exp_gnt));
            // read return, in command order per client
            for (int k = 0; k < NUM_CLIENTS; k++)
            begin
                if (rd_valid[k])
                begin
                    if (exp_rd_q[k].size() == 0)
                    begin
                        $display("read data returned to client %0d with no read pending", k);
                        abort_run();
                    end
                    else
                        check_value($sformatf("read data of client %0d", k),
                                    32'(rd_data), 32'(exp_rd_q[k].pop_front()));
                end
            end
            // request levels as the arbiter sees them in this cycle
            for (int k = 0; k < NUM_CLIENTS; k++)
                model_req[k] = (pending_cnt[k] > 0) && !gnt[k];
            exp_gnt = predict_grant(model_req, block_arb, have_prev, prev_win);
            for (int k = 0; k < NUM_CLIENTS; k++)
            begin
                if (exp_gnt[k])
                begin
                    prev_win  = k;
                    have_prev = 1'b1;
                end
            end
            // grant pops, accept pushes
            for (int k = 0; k < NUM_CLIENTS; k++)
            begin
                if (gnt[k])
                    pending_cnt[k]--;
                if (cmd_valid[k] && cmd_ready[k])
                    model_accept(k, cmd[k]);
            end
        end
    end

    // ========================================
    // stimulus helpers
    // ========================================

    // random command inside the address range of client k
    // an address never written is always written first
    function automatic mem_share_pkg::mem_cmd_t make_cmd(input int k);
        mem_share_pkg::mem_cmd_t c;
        logic [31:0]             r;
        r      = rand_bits(mem_share_pkg::ADDR_W - 2);
        c.addr = {2'(k), r[mem_share_pkg::ADDR_W-3:0]};
        r      = rand_bits(1);
        c.wr   = r[0] | ~model_written[c.addr];
        r      = rand_bits(mem_share_pkg::DATA_W);
        c.data = r[mem_share_pkg::DATA_W-1:0];
        return c;
    endfunction

    // called on a falling edge, returns on the falling edge after the accept
    task automatic send_cmd(input int k, input mem_share_pkg::mem_cmd_t c);
        int waited;
        waited       = 0;
        cmd_valid[k] = 1'b1;
        cmd[k]       = c;
        while (!cmd_ready[k])
        begin
            if (waited == TIMEOUT)
                report_timeout($sformatf("command accept on client %0d", k));
            else
            begin
                @(negedge clk);
                waited++;
            end
        end
        @(negedge clk);
        cmd_valid[k] = 1'b0;
    endtask

    task automatic wait_grant(input int k);
        int waited;
        waited = 0;
        while (!gnt[k])
        begin
            if (waited == TIMEOUT)
                report_timeout($sformatf("grant of client %0d", k));
            else
            begin
                @(negedge clk);
                waited++;
            end
        end
    endtask

    // all queued commands granted and all reads returned
    task automatic drain();
        int waited;
        bit busy;
        waited = 0;
        busy   = 1'b1;
        while (busy)
        begin
            busy = 1'b0;
            for (int k = 0; k < NUM_CLIENTS; k++)
            begin
                if (pending_cnt[k] != 0 || exp_rd_q[k].size() != 0)
                    busy = 1'b1;
            end
            if (busy && waited == TIMEOUT)
                report_timeout("outstanding commands to drain");
            else if (busy)
            begin
                @(negedge clk);
                waited++;
            end
        end
    endtask

    // block held, o_gnt must stay quiet
    task automatic hold_blocked(input int cycles);
        for (int i = 0; i < cycles; i++)
        begin
            @(negedge clk);
            check_value("grant while blocked", 32'(gnt), 32'd0);
        end
    endtask

    // ========================================
    // test sequence
    // ========================================

    initial
    begin
        mem_share_pkg::mem_cmd_t c;
        logic [NUM_CLIENTS-1:0]  last_ready;
        logic [NUM_CLIENTS-1:0]  seen;
        logic [31:0]             r;
        int                      gnt_seq [2*NUM_CLIENTS];
        int                      issued;
        int                      n;
        int                      waited;

        clk       = 1'b0;
        rst_n     = 1'b0;
        block_arb = 1'b0;
        cmd_valid = '0;
        for (int k = 0; k < NUM_CLIENTS; k++)
            cmd[k] = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // quiet outputs straight after reset
        @(negedge clk);
        check_value("grant after reset", 32'(gnt), 32'd0);
        check_value("read valid after reset", 32'(rd_valid), 32'd0);
        check_value("ready after reset", 32'(cmd_ready), 32'({NUM_CLIENTS{1'b1}}));

        // single client write then read back
        c    = make_cmd(1);
        c.wr = 1'b1;
        send_cmd(1, c);
        wait_grant(1);
        check_value("single client write grant", 32'(gnt), 32'(4'b0010));
        @(negedge clk);
        c.wr = 1'b0;
        send_cmd(1, c);
        wait_grant(1);
        // registered read answers in the cycle after the grant
        @(negedge clk);
        check_value("read valid owner", 32'(rd_valid), 32'(4'b0010));
        check_value("read back data", 32'(rd_data), 32'(c.data));
        drain();

        // back-pressure on client 2 while arbitration is frozen
        block_arb = 1'b1;
        for (int i = 0; i < FIFO_DEPTH; i++)
        begin
            check_value("ready before FIFO full", 32'(cmd_ready[2]), 32'd1);
            send_cmd(2, make_cmd(2));
        end
        check_value("ready with FIFO full", 32'(cmd_ready[2]), 32'd0);
        c            = make_cmd(2);
        cmd_valid[2] = 1'b1;
        cmd[2]       = c;
        hold_blocked(8);
        check_value("ready held low", 32'(cmd_ready[2]), 32'd0);
        block_arb = 1'b0;
        send_cmd(2, c);
        drain();

        // fairness with every FIFO full
        block_arb = 1'b1;
        for (int k = 0; k < NUM_CLIENTS; k++)
        begin
            for (int i = 0; i < FIFO_DEPTH; i++)
                send_cmd(k, make_cmd(k));
        end
        hold_blocked(6);
        block_arb = 1'b0;
        n      = 0;
        waited = 0;
        while (n < 2 * NUM_CLIENTS)
        begin
            if (waited == TIMEOUT)
                report_timeout("two rounds of grants");
            else
            begin
                @(negedge clk);
                waited++;
                for (int k = 0; k < NUM_CLIENTS; k++)
                begin
                    if (gnt[k])
                        gnt_seq[n] = k;
                end
                if (gnt != '0)
                    n++;
            end
        end
        // every window of NUM_CLIENTS grants names each client once
        for (int w = 0; w <= NUM_CLIENTS; w++)
        begin
            seen = '0;
            for (int j = 0; j < NUM_CLIENTS; j++)
                seen = seen | (NUM_CLIENTS'(1) << gnt_seq[w + j]);
            check_value($sformatf("grant window at %0d", w), 32'(seen),
                        32'({NUM_CLIENTS{1'b1}}));
        end
        drain();

        // random mixed traffic from all clients, block toggled now and then
        issued     = 0;
        waited     = 0;
        last_ready = '0;
        while (issued < NUM_RANDOM || cmd_valid != '0)
        begin
            for (int k = 0; k < NUM_CLIENTS; k++)
            begin
                // valid and ready in the last cycle means it went in
                if (cmd_valid[k] && last_ready[k])
                    cmd_valid[k] = 1'b0;
                if (!cmd_valid[k] && issued < NUM_RANDOM)
                begin
                    r = rand_bits(2);
                    if (r[1:0] != 2'd0)
                    begin
                        cmd[k]       = make_cmd(k);
                        cmd_valid[k] = 1'b1;
                        issued++;
                    end
                end
            end
            r          = rand_bits(4);
            block_arb  = (r[3:0] == 4'd0);
            last_ready = cmd_ready;
            if (waited == 100 * TIMEOUT)
                report_timeout("random traffic to be accepted");
            else
            begin
                @(negedge clk);
                waited++;
            end
        end
        block_arb = 1'b0;
        drain();

        repeat (4) @(negedge clk);
        $display("test passed");
        $finish;
    end

endmodule : mem_share_tb

`default_nettype wire

/* mem_share_top.f */
+incdir+tests
logic/mem_share_pkg.sv
logic/leading_one_trailing_one.sv
logic/round_robin_arbiter.sv
logic/mem_client.sv
logic/sram_port.sv
logic/mem_share_top.sv
tests/mem_share_tb.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator
# the run passes only when the pass line shows up in the simulation output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module mem_share_tb -f mem_share_top.f -o mem_share_sim \
    && ./obj_dir/mem_share_sim | tee /dev/stderr | grep -q "test passed" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
